//--- ram_uart_defines.svh
`ifndef RAM_UART_DEFINES_SVH
`define RAM_UART_DEFINES_SVH

// Data bus and CPU value width
`define DATA_W 16

// SRAM address width
`define ADDR_W 18

// One bus tick is 2**RAM_DIV_BITS clocks
`define RAM_DIV_BITS 2

// Receive queue
`define QUEUE_DEPTH 16
`define QUEUE_PTR_W 4

// Address decoded as the UART data port
`define UART_ADDR 18'h0BF00

`endif

//--- ram_uart_pkg.sv
`include "ram_uart_defines.svh"

package ram_uart_pkg;

	typedef logic [`DATA_W-1:0] word_t;
	typedef logic [`ADDR_W-1:0] addr_t;

	// Occupancy needs one bit more than the pointers
	typedef logic [`QUEUE_PTR_W:0] qlevel_t;

	typedef enum logic [2:0] {
		RAM_RD,
		RAM_WR,
		UART_TX,
		UART_POP,
		BAD_REQ
	} req_kind_t;

	typedef enum logic [4:0] {
		IDLE,
		RX1, RX2, RX3, RX4,
		TX1, TX2, TX3, TX4, TX5,
		RAM_RD1, RAM_RD2, RAM_RD3,
		RAM_WR1, RAM_WR2, RAM_WR3,
		POP1, POP2,
		FAULT
	} seq_state_t;

endpackage

//--- ram_uart_ifs.sv
`timescale 1ns/1ps

// Decoded CPU request, pending while valid is high
interface mem_req_if import ram_uart_pkg::*; ();
	logic valid;
	req_kind_t kind;
	addr_t addr;
	word_t wdata;
	logic take;

	modport decode (
		output valid,
		output kind,
		output addr,
		output wdata,
		input take
	);

	modport execute (
		input valid,
		input kind,
		input addr,
		input wdata,
		output take
	);
endinterface

// Strobes from the bus sequencer into the receive queue and result register
interface rx_path_if import ram_uart_pkg::*; ();
	logic push;
	logic pop;
	logic load_ram;
	word_t bus_in;
	logic full;

	modport execute (
		output push,
		output pop,
		output load_ram,
		output bus_in,
		input full
	);

	modport result (
		input push,
		input pop,
		input load_ram,
		input bus_in,
		output full
	);
endinterface

//--- req_decode.sv
`timescale 1ns/1ps
`include "ram_uart_defines.svh"

module req_decode import ram_uart_pkg::*; (
	input logic clk,
	input logic rst,
	input logic need_to_work,
	input logic mem_rd,
	input logic mem_wr,
	input addr_t mem_addr,
	input word_t mem_value,
	mem_req_if.decode req
);

	logic accept;
	logic is_uart;
	req_kind_t kind_in;

	// Strobes while a request is still pending are dropped
	assign accept = need_to_work && !req.valid;
	assign is_uart = mem_addr == `UART_ADDR;

	// Write wins over read
	always_comb begin
		if (mem_wr) begin
			kind_in = is_uart ? UART_TX : RAM_WR;
		end else if (mem_rd) begin
			kind_in = is_uart ? UART_POP : RAM_RD;
		end else begin
			kind_in = BAD_REQ;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			req.valid <= 1'b0;
		end else if (accept) begin
			req.valid <= 1'b1;
		end else if (req.take) begin
			req.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req.kind <= kind_in;
			req.addr <= mem_addr;
			req.wdata <= mem_value;
		end
	end

endmodule

//--- bus_sequencer.sv
`timescale 1ns/1ps
`include "ram_uart_defines.svh"

module bus_sequencer import ram_uart_pkg::*; (
	input logic clk,
	input logic rst,
	mem_req_if.execute req,
	rx_path_if.execute rx,
	input word_t ram_data_in,
	input logic data_ready,
	input logic tbre,
	input logic tsre,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	output logic rdn,
	output logic wrn,
	output logic bus_drive,
	output logic work_done,
	output logic bus_error
);

	localparam logic [`RAM_DIV_BITS-1:0] CNT_LAST = '1;
	localparam logic [`RAM_DIV_BITS-1:0] CNT_PRE = CNT_LAST - 1'b1;

	logic [`RAM_DIV_BITS-1:0] cnt;
	logic tick;
	logic strobe_slot;
	logic rx_start;
	logic final_state;
	seq_state_t state;
	seq_state_t nxt;

	////////////////////////////////////////////////////////////
	// Tick divider and request hand-off
	////////////////////////////////////////////////////////////

	// State changes at the end of the last clock of a tick
	assign tick = cnt == CNT_LAST;
	// One clock earlier, so loaded data is ready with work_done
	assign strobe_slot = cnt == CNT_PRE;

	// Receive has priority, unless the queue has no room
	assign rx_start = data_ready && !rx.full;
	assign req.take = tick && state == IDLE && !rx_start && req.valid;

	assign final_state = state inside {RAM_RD3, RAM_WR3, TX5, POP2, FAULT};

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb begin
		nxt = state;
		case (state)
			IDLE: begin
				if (rx_start) begin
					nxt = RX1;
				end else if (req.valid) begin
					case (req.kind)
						RAM_RD: nxt = RAM_RD1;
						RAM_WR: nxt = RAM_WR1;
						UART_TX: nxt = TX1;
						UART_POP: nxt = POP1;
						default: nxt = FAULT;
					endcase
				end
			end
			RX1: begin
				if (data_ready) nxt = RX2;
			end
			RX2: nxt = RX3;
			RX3: nxt = RX4;
			RX4: nxt = IDLE;
			TX1: nxt = TX2;
			TX2: nxt = TX3;
			TX3: begin
				if (tbre) nxt = TX4;
			end
			TX4: begin
				if (tsre) nxt = TX5;
			end
			TX5: nxt = IDLE;
			RAM_RD1: nxt = RAM_RD2;
			RAM_RD2: nxt = RAM_RD3;
			RAM_RD3: nxt = IDLE;
			RAM_WR1: nxt = RAM_WR2;
			RAM_WR2: nxt = RAM_WR3;
			RAM_WR3: nxt = IDLE;
			POP1: nxt = POP2;
			POP2: nxt = IDLE;
			default: nxt = IDLE;
		endcase
	end

	// Pin levels held for the whole of a state
	function automatic logic [5:0] pins_for(seq_state_t s);
		logic [5:0] p;
		// {ram_en, ram_oe, ram_we, rdn, wrn, bus_drive}
		case (s)
			RAM_RD1, RAM_RD2, RAM_RD3: p = 6'b001110;
			RAM_WR1, RAM_WR3: p = 6'b011111;
			RAM_WR2: p = 6'b010111;
			RX2, RX3: p = 6'b111010;
			TX1, TX2: p = 6'b111101;
			// Data stays on the bus past the wrn rise
			TX3, TX4, TX5: p = 6'b111111;
			default: p = 6'b111110;
		endcase
		return p;
	endfunction

	////////////////////////////////////////////////////////////
	// State, pins and completion
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt <= '0;
			state <= IDLE;
			{ram_en, ram_oe, ram_we, rdn, wrn, bus_drive} <= 6'b111110;
			work_done <= 1'b0;
			bus_error <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
			if (tick) begin
				state <= nxt;
				{ram_en, ram_oe, ram_we, rdn, wrn, bus_drive} <= pins_for(nxt);
			end
			work_done <= strobe_slot && final_state;
			if (state == FAULT) bus_error <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		rx.bus_in <= ram_data_in;
	end

	assign rx.push = state == RX3 && strobe_slot;
	assign rx.load_ram = state == RAM_RD3 && strobe_slot;
	assign rx.pop = state == POP2 && strobe_slot;

endmodule

//--- rx_queue_result.sv
`timescale 1ns/1ps
`include "ram_uart_defines.svh"

module rx_queue_result import ram_uart_pkg::*; (
	input logic clk,
	input logic rst,
	rx_path_if.result rx,
	output word_t result,
	output qlevel_t rx_level
);

	word_t queue [`QUEUE_DEPTH];
	logic [`QUEUE_PTR_W-1:0] front;
	logic [`QUEUE_PTR_W-1:0] tail;
	qlevel_t level;
	logic empty;
	logic do_push;
	logic do_pop;

	assign empty = level == '0;
	assign rx.full = level == qlevel_t'(`QUEUE_DEPTH);
	assign do_push = rx.push && !rx.full;
	assign do_pop = rx.pop && !empty;
	assign rx_level = level;

	////////////////////////////////////////////////////////////
	// Circular receive queue
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			front <= '0;
			tail <= '0;
			level <= '0;
		end else begin
			if (do_push) tail <= tail + 1'b1;
			if (do_pop) front <= front + 1'b1;
			case ({do_push, do_pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			queue[tail] <= rx.bus_in;
		end
	end

	////////////////////////////////////////////////////////////
	// CPU result register
	////////////////////////////////////////////////////////////

	// Pop of an empty queue reads as zero
	always_ff @(posedge clk) begin
		if (rx.load_ram) begin
			result <= rx.bus_in;
		end else if (rx.pop) begin
			result <= empty ? '0 : queue[front];
		end
	end

endmodule

//--- ram_uart_top.sv
`timescale 1ns/1ps

module ram_uart_top import ram_uart_pkg::*; (
	input logic clk,
	input logic rst,
	input logic need_to_work,
	input logic mem_rd,
	input logic mem_wr,
	input addr_t mem_addr,
	input word_t mem_value,
	input logic data_ready,
	input logic tbre,
	input logic tsre,
	output addr_t ram_addr,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	output logic rdn,
	output logic wrn,
	output logic work_done,
	output word_t result,
	output qlevel_t rx_level,
	output logic bus_error,
	inout wire word_t ram_data
);

	logic bus_drive;

	mem_req_if req_bus ();
	rx_path_if rx_bus ();

	// Latched write value goes out on the shared bus
	assign ram_data = bus_drive ? req_bus.wdata : 'z;
	assign ram_addr = req_bus.addr;

	req_decode decode_i (
		.clk(clk),
		.rst(rst),
		.need_to_work(need_to_work),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.mem_addr(mem_addr),
		.mem_value(mem_value),
		.req(req_bus.decode)
	);

	bus_sequencer seq_i (
		.clk(clk),
		.rst(rst),
		.req(req_bus.execute),
		.rx(rx_bus.execute),
		.ram_data_in(ram_data),
		.data_ready(data_ready),
		.tbre(tbre),
		.tsre(tsre),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.rdn(rdn),
		.wrn(wrn),
		.bus_drive(bus_drive),
		.work_done(work_done),
		.bus_error(bus_error)
	);

	rx_queue_result result_i (
		.clk(clk),
		.rst(rst),
		.rx(rx_bus.result),
		.result(result),
		.rx_level(rx_level)
	);

endmodule

//--- ram_uart_assertions.sv
`timescale 1ns/1ps

module ram_uart_assertions (
	input logic clk,
	input logic rst,
	input logic ram_oe,
	input logic ram_we,
	input logic rdn,
	input logic wrn,
	input logic bus_drive
);

	// SRAM output enable and write enable never overlap
	oe_we_exclusive: assert property (@(posedge clk) disable iff (!rst)
		ram_oe || ram_we)
		else $error("ram_oe and ram_we low together");

	uart_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst)
		rdn || wrn)
		else $error("rdn and wrn low together");

	// No bus fight with the SRAM or the UART chip
	no_bus_fight: assert property (@(posedge clk) disable iff (!rst)
		bus_drive |-> (ram_oe && rdn))
		else $error("data bus driven while ram_oe or rdn is low");

endmodule

bind ram_uart_top ram_uart_assertions asrt_i (
	.clk(clk),
	.rst(rst),
	.ram_oe(ram_oe),
	.ram_we(ram_we),
	.rdn(rdn),
	.wrn(wrn),
	.bus_drive(bus_drive)
);

//--- tb_ram_uart.sv
`timescale 1ns/1ps
`include "ram_uart_defines.svh"

module tb_ram_uart import ram_uart_pkg::*; ();

	localparam int MAX_VEC = 64;

	logic clk = 1'b0;
	logic rst;
	logic need_to_work;
	logic mem_rd;
	logic mem_wr;
	addr_t mem_addr;
	word_t mem_value;
	logic data_ready;
	logic tbre;
	logic tsre;
	addr_t ram_addr;
	logic ram_en;
	logic ram_oe;
	logic ram_we;
	logic rdn;
	logic wrn;
	logic work_done;
	word_t result;
	qlevel_t rx_level;
	logic bus_error;
	wire word_t ram_data;

	word_t sram [0:(1 << `ADDR_W) - 1];
	word_t rx_byte;
	logic [31:0] vec [0:4*MAX_VEC-1];
	int n_vec;
	logic vec_ready;
	logic bad_seen;
	int errors;
	int checks;
	integer seed;

	always #20 clk = ~clk;

	ram_uart_top dut_i (.*);

	////////////////////////////////////////////////////////////
	// SRAM and UART chip models
	////////////////////////////////////////////////////////////

	assign ram_data = (!ram_en && !ram_oe) ? sram[ram_addr] : (!rdn ? rx_byte : 'z);

	always @(posedge ram_we) begin
		if (rst && !ram_en) begin
			sram[ram_addr] <= ram_data;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Random UART busy time of 1 to 16 clocks
	function automatic int rand_delay();
		return ($random(seed) & 32'hf) + 1;
	endfunction

	task automatic issue_request(input logic rd, input logic wr, input addr_t addr,
		input word_t value);
		@(negedge clk);
		mem_rd = rd;
		mem_wr = wr;
		mem_addr = addr;
		mem_value = value;
		need_to_work = 1'b1;
		@(negedge clk);
		need_to_work = 1'b0;
	endtask

	task automatic wait_done();
		do @(negedge clk); while (work_done !== 1'b1);
	endtask

	task automatic wait_rdn(input logic level);
		do @(negedge clk); while (rdn !== level);
	endtask

	// UART chip drops data_ready once the byte has been read
	task automatic finish_receive();
		wait_rdn(1'b0);
		wait_rdn(1'b1);
		data_ready = 1'b0;
	endtask

	task automatic receive_byte(input word_t value);
		@(negedge clk);
		rx_byte = value;
		data_ready = 1'b1;
		finish_receive();
	endtask

	initial begin : watchdog
		wait (vec_ready);
		repeat (n_vec * 200) @(posedge clk);
		$display("run did not finish within %0d cycles", n_vec * 200);
		$display("SIMULATION FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Vector sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] op;
		logic [31:0] addr_v;
		logic [31:0] data_v;
		logic [31:0] exp_v;
		logic flag;
		string name;
		rst = 1'b0;
		need_to_work = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		mem_addr = '0;
		mem_value = '0;
		data_ready = 1'b0;
		tbre = 1'b1;
		tsre = 1'b1;
		rx_byte = '0;
		seed = 32'hfd5b;
		errors = 0;
		checks = 0;
		n_vec = 0;
		vec_ready = 1'b0;
		bad_seen = 1'b0;
		$readmemh("ram_uart_vectors.txt", vec);
		while (n_vec < MAX_VEC && vec[4*n_vec] != 32'h0) n_vec++;
		if (n_vec == 0) begin
			errors++;
			$display("no vectors found in ram_uart_vectors.txt");
		end else begin
			vec_ready = 1'b1;
		end
		repeat (16) @(negedge clk);
		rst = 1'b1;
		for (int i = 0; i < n_vec; i++) begin
			op = vec[4*i];
			addr_v = vec[4*i+1];
			data_v = vec[4*i+2];
			exp_v = vec[4*i+3];
			name = $sformatf("vector %0d", i);
			flag = 1'b0;
			case (op)
				32'd1: begin
					issue_request(1'b0, 1'b1, addr_v[`ADDR_W-1:0], data_v[`DATA_W-1:0]);
					wait_done();
					check_value({name, " sram word"}, exp_v,
						{16'h0, sram[addr_v[`ADDR_W-1:0]]});
				end
				32'd2: begin
					issue_request(1'b1, 1'b0, addr_v[`ADDR_W-1:0], '0);
					wait_done();
					check_value({name, " read result"}, exp_v, {16'h0, result});
					// Sticky error flag, low until the first bad request
					check_value({name, " bus error"}, {31'h0, bad_seen},
						{31'h0, bus_error});
				end
				32'd3: begin
					issue_request(1'b0, 1'b1, addr_v[`ADDR_W-1:0], data_v[`DATA_W-1:0]);
					do @(negedge clk); while (wrn !== 1'b0);
					check_value({name, " uart tx data"}, exp_v, {16'h0, ram_data});
					tbre = 1'b0;
					tsre = 1'b0;
					do begin
						@(negedge clk);
						flag = flag | work_done;
					end while (wrn !== 1'b1);
					repeat (rand_delay()) begin
						@(negedge clk);
						flag = flag | work_done;
					end
					tbre = 1'b1;
					repeat (rand_delay()) begin
						@(negedge clk);
						flag = flag | work_done;
					end
					tsre = 1'b1;
					wait_done();
					check_value({name, " done before tsre"}, 32'h0, {31'h0, flag});
				end
				32'd4: begin
					// Address column holds the byte count
					for (int k = 0; k < addr_v; k++) begin
						receive_byte(word_t'(data_v + k));
						check_value({name, " rx level"}, exp_v - addr_v + k + 1,
							{27'h0, rx_level});
					end
				end
				32'd5: begin
					issue_request(1'b0, 1'b0, addr_v[`ADDR_W-1:0], '0);
					wait_done();
					check_value({name, " bus error"}, exp_v, {31'h0, bus_error});
					bad_seen = 1'b1;
				end
				32'd6: begin
					@(negedge clk);
					check_value({name, " rx level"}, exp_v, {27'h0, rx_level});
				end
				32'd7: begin
					@(negedge clk);
					rx_byte = data_v[`DATA_W-1:0];
					data_ready = 1'b1;
					repeat (12 << `RAM_DIV_BITS) begin
						@(negedge clk);
						flag = flag | !rdn;
					end
					check_value({name, " rdn while full"}, 32'h0, {31'h0, flag});
					check_value({name, " rx level"}, exp_v, {27'h0, rx_level});
				end
				32'd8: begin
					finish_receive();
					check_value({name, " rx level"}, exp_v, {27'h0, rx_level});
				end
				default: begin
					errors++;
					$display("unknown operation code %0h in vector %0d", op, i);
				end
			endcase
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- ram_uart_vectors.txt
// Columns are op, address, data, expected value, all hex
// Op 1 ram write, 2 read, 3 uart send, 4 receive (address = count), 5 no rd or wr,
// 6 rx_level check, 7 receive held off by a full queue, 8 finish held receive, 0 end
1 00012 a5c3 a5c3
2 00012 0000 a5c3
1 3ffff 1234 1234
1 00013 0f0f 0f0f
2 3ffff 0000 1234
2 00013 0000 0f0f
3 0bf00 0041 0041
3 0bf00 005a 005a
2 0bf00 0000 0000
6 00000 0000 0000
4 00003 0011 0003
2 0bf00 0000 0011
2 0bf00 0000 0012
6 00000 0000 0001
2 0bf00 0000 0013
6 00000 0000 0000
4 00010 0030 0010
7 00000 0077 0010
2 0bf00 0000 0030
8 00000 0000 0010
2 0bf00 0000 0031
6 00000 0000 000f
5 00100 0000 0001
2 00012 0000 a5c3
0 00000 0000 0000

//--- ram_uart.f
+incdir+.
ram_uart_pkg.sv
ram_uart_ifs.sv
req_decode.sv
bus_sequencer.sv
rx_queue_result.sv
ram_uart_top.sv
ram_uart_assertions.sv
tb_ram_uart.sv

//--- Makefile
TOP = tb_ram_uart

all: run

build:
	verilator --binary --timing --assert -f ram_uart.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1; rc=$$?; cat sim.log; \
	if [ $$rc -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f ram_uart.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
